//--- all.f
design/mac_pkg.sv
design/mac_regfile.sv
design/mac_ctrl.sv
design/mac_engine.sv
design/mac_top.sv
verification/mac_chk.sv
verification/mac_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = mac_tb
FILELIST  = all.f

.PHONY: sim clean

# the run passes only when the testbench printed its pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | awk '{ print } /^>>> PASS$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

//--- verification/mac_tb.sv
`timescale 1ns/100ps

module mac_tb;

  import mac_pkg::*;

  localparam int max_len     = 16;
  localparam int clk_period  = 20;
  localparam int n_jobs      = 9;
  // generous per-item and per-job cycle bounds for the watchdog
  localparam int item_cycles = 40;
  localparam int job_cycles  = 60;

  localparam logic [1:0] evt_none    = 2'd0;
  localparam logic [1:0] evt_clear   = 2'd1;
  localparam logic [1:0] evt_restart = 2'd2;

  typedef struct packed {
    logic       mul;
    logic [4:0] len;
    logic [5:0] sh;
    logic       bp;
    logic [1:0] evt;
  } job_t;

  // columns are multiply mode, length, shift, random d back-pressure, mid-job host event
  localparam job_t jobs [n_jobs] = '{
    '{1'b1, 5'd4,  6'd0, 1'b0, evt_none},
    '{1'b1, 5'd8,  6'd3, 1'b1, evt_none},
    '{1'b0, 5'd5,  6'd2, 1'b0, evt_none},
    '{1'b0, 5'd16, 6'd7, 1'b1, evt_none},
    '{1'b1, 5'd8,  6'd1, 1'b1, evt_clear},
    '{1'b0, 5'd6,  6'd4, 1'b0, evt_none},
    '{1'b0, 5'd8,  6'd0, 1'b1, evt_clear},
    '{1'b1, 5'd6,  6'd2, 1'b1, evt_restart},
    '{1'b0, 5'd10, 6'd3, 1'b1, evt_restart}
  };

  logic        clk_i;
  logic        rst_ni;
  logic        reg_we_i;
  logic [1:0]  reg_addr_i;
  logic [31:0] reg_wdata_i;
  logic [31:0] reg_rdata_o;
  logic        a_valid_i;
  logic        a_ready_o;
  logic [31:0] a_data_i;
  logic        b_valid_i;
  logic        b_ready_o;
  logic [31:0] b_data_i;
  logic        c_valid_i;
  logic        c_ready_o;
  logic [31:0] c_data_i;
  logic        d_valid_o;
  logic        d_ready_i;
  logic [31:0] d_data_o;
  logic        done_o;
  logic [31:0] lfsr_q;

  mac_top #(
    .max_len (max_len)
  ) mac_top_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .reg_we_i    (reg_we_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (reg_rdata_o),
    .a_valid_i   (a_valid_i),
    .a_ready_o   (a_ready_o),
    .a_data_i    (a_data_i),
    .b_valid_i   (b_valid_i),
    .b_ready_o   (b_ready_o),
    .b_data_i    (b_data_i),
    .c_valid_i   (c_valid_i),
    .c_ready_o   (c_ready_o),
    .c_data_i    (c_data_i),
    .d_valid_o   (d_valid_o),
    .d_ready_i   (d_ready_i),
    .d_data_o    (d_data_o),
    .done_o      (done_o)
  );

  // pipeline handshake rules watched inside every engine
  bind mac_engine mac_chk #(
    .max_len (max_len)
  ) mac_chk_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .clear_i        (clear_i),
    .r_mult_i       (r_mult),
    .r_mult_valid_i (r_mult_valid),
    .mult_fire_i    (mult_fire),
    .r_acc_i        (r_acc),
    .r_acc_valid_i  (r_acc_valid),
    .acc_fire_i     (acc_fire),
    .d_valid_i      (d_valid_o),
    .d_ready_i      (d_ready_i),
    .d_data_i       (d_data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(clk_period / 2) clk_i = ~clk_i;
  end

  // galois lfsr over x^32 + x^22 + x^2 + x + 1, one step per bit handed out
  function automatic logic lfsr_bit();
    logic out;
    out    = lfsr_q[0];
    lfsr_q = (lfsr_q >> 1) ^ (out ? 32'h80200003 : 32'h0);
    return out;
  endfunction

  // 12-bit signed operand, sign-extended to the stream width
  function automatic logic [31:0] rand_operand();
    logic [11:0] v;
    for (int i = 0; i < 12; i++) begin
      v[i] = lfsr_bit();
    end
    return {{20{v[11]}}, v};
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display(">>> FAIL");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  task automatic write_reg(input logic [1:0] addr, input logic [31:0] data);
    @(negedge clk_i);
    reg_we_i    = 1'b1;
    reg_addr_i  = addr;
    reg_wdata_i = data;
    @(negedge clk_i);
    reg_we_i    = 1'b0;
  endtask

  // the read port is combinational, so sample well before the next rising edge
  task automatic read_reg(input logic [1:0] addr, output logic [31:0] data);
    @(negedge clk_i);
    reg_addr_i = addr;
    #(clk_period / 4);
    data = reg_rdata_o;
  endtask

  task automatic run_job(input int j);
    job_t        job;
    logic [31:0] a_op [max_len];
    logic [31:0] b_op [max_len];
    logic [31:0] c_op;
    logic [31:0] exp_q [$];
    logic [31:0] rd;
    logic [31:0] ctrl_lvl;
    logic [31:0] exp_status;
    longint      prod;
    longint      acc;
    int          a_idx;
    int          b_idx;
    int          cyc;
    int          tail;
    int          dones;
    logic        c_done;
    logic        stopped;

    job = jobs[j];
    // reference model, the preload is c moved up to the product's fixed-point scale
    c_op = rand_operand();
    acc  = longint'($signed(c_op)) <<< job.sh;
    for (int i = 0; i < int'(job.len); i++) begin
      a_op[i] = rand_operand();
      b_op[i] = rand_operand();
      prod    = longint'($signed(a_op[i])) * longint'($signed(b_op[i]));
      acc     = acc + prod;
      if (job.mul) begin
        exp_q.push_back(32'(prod >>> job.sh));
      end
    end
    if (!job.mul) begin
      exp_q.push_back(32'(acc >>> job.sh));
    end

    write_reg(reg_len, 32'(job.len));
    write_reg(reg_shift, 32'(job.sh));
    read_reg(reg_len, rd);
    check_eq("reg_len", rd, 32'(job.len));
    read_reg(reg_shift, rd);
    check_eq("reg_shift", rd, 32'(job.sh));
    ctrl_lvl                      = 32'd0;
    ctrl_lvl[ctrl_simple_mul_bit] = job.mul;
    ctrl_lvl[ctrl_enable_bit]     = 1'b1;
    write_reg(reg_ctrl, ctrl_lvl | 32'(1 << ctrl_start_bit));

    a_idx   = 0;
    b_idx   = 0;
    cyc     = 0;
    tail    = 0;
    dones   = 0;
    c_done  = job.mul;
    stopped = 1'b0;
    while (tail < 4) begin
      @(negedge clk_i);
      reg_we_i  = 1'b0;
      // c goes first in a scalar product, the pairs follow once it is taken
      c_valid_i = !stopped && !c_done;
      c_data_i  = c_op;
      // a and b are separate sources, each holds its word until its own transfer
      a_valid_i = !stopped && c_done && (a_idx < int'(job.len));
      b_valid_i = !stopped && c_done && (b_idx < int'(job.len));
      if (a_idx < int'(job.len)) begin
        a_data_i = a_op[a_idx];
      end
      if (b_idx < int'(job.len)) begin
        b_data_i = b_op[b_idx];
      end
      d_ready_i = job.bp ? lfsr_bit() : 1'b1;
      if ((cyc == 3) && (job.evt != evt_none)) begin
        reg_we_i    = 1'b1;
        reg_addr_i  = reg_ctrl;
        reg_wdata_i = ctrl_lvl;
        reg_wdata_i[(job.evt == evt_clear) ? ctrl_clear_bit : ctrl_start_bit] = 1'b1;
        stopped     = (job.evt == evt_clear);
      end
      #(clk_period / 4);
      if (a_valid_i && a_ready_o) begin
        a_idx++;
      end
      if (b_valid_i && b_ready_o) begin
        b_idx++;
      end
      if (c_valid_i && c_ready_o) begin
        c_done = 1'b1;
      end
      if (d_valid_o && d_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("d delivered a result beyond the expected count at %0t ns", $time);
          $display(">>> FAIL");
          $fatal(1, "extra result");
        end else begin
          check_eq("d_data_o", d_data_o, exp_q.pop_front());
        end
      end
      if (done_o) begin
        // done marks the end of the job, every result has left by then
        check_eq("results left at done_o", 32'(exp_q.size()), 32'd0);
        dones++;
      end
      cyc++;
      if (stopped || ((exp_q.size() == 0) && (dones > 0))) begin
        tail++;
      end
    end

    // an aborted job leaves busy, done and the count all at zero
    exp_status = 32'd0;
    if (job.evt != evt_clear) begin
      exp_status = {25'd0, job.len, 2'b10};
    end
    check_eq("done_o pulses", 32'(dones), (job.evt == evt_clear) ? 32'd0 : 32'd1);
    read_reg(reg_status, rd);
    check_eq("reg_status", rd, exp_status);
  endtask

  initial begin
    logic [31:0] rd;
    lfsr_q      = 32'hdeaa5a6e;
    rst_ni      = 1'b0;
    reg_we_i    = 1'b0;
    reg_addr_i  = reg_ctrl;
    reg_wdata_i = 32'd0;
    a_valid_i   = 1'b0;
    a_data_i    = 32'd0;
    b_valid_i   = 1'b0;
    b_data_i    = 32'd0;
    c_valid_i   = 1'b0;
    c_data_i    = 32'd0;
    d_ready_i   = 1'b0;
    // five rising edges under reset, then release on the falling edge
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    #(clk_period / 4);
    check_eq("d_valid_o", 32'(d_valid_o), 32'd0);
    check_eq("done_o", 32'(done_o), 32'd0);
    read_reg(reg_status, rd);
    check_eq("reg_status", rd, 32'd0);
    for (int j = 0; j < n_jobs; j++) begin
      run_job(j);
    end
    $display(">>> PASS");
    $finish;
  end

  // run limit grows with the total number of stream items in the table
  initial begin : watchdog
    int total_len;
    total_len = 0;
    for (int j = 0; j < n_jobs; j++) begin
      total_len += int'(jobs[j].len);
    end
    #((total_len * item_cycles + n_jobs * job_cycles + 20) * clk_period);
    $display("the run hung: the jobs did not finish within the time limit");
    $display(">>> FAIL");
    $fatal(1, "timeout");
  end

endmodule

//--- verification/mac_chk.sv
`timescale 1ns/100ps

module mac_chk #(
  parameter int unsigned max_len = 16
) (
  input logic                                            clk_i,
  input logic                                            rst_ni,
  input logic                                            clear_i,
  input logic [mac_pkg::prod_w-1:0]                      r_mult_i,
  input logic                                            r_mult_valid_i,
  input logic                                            mult_fire_i,
  input logic [mac_pkg::prod_w+$clog2(max_len)-1:0]      r_acc_i,
  input logic                                            r_acc_valid_i,
  input logic                                            acc_fire_i,
  input logic                                            d_valid_i,
  input logic                                            d_ready_i,
  input logic [mac_pkg::data_w-1:0]                      d_data_i
);

  // a product that is not taken keeps its value and stays valid
  mult_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    r_mult_valid_i && !mult_fire_i |=> r_mult_valid_i && $stable(r_mult_i))
    else $error("product register changed or dropped before its transfer");

  // the finished sum waits the same way until d takes it
  acc_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    r_acc_valid_i && !acc_fire_i |=> r_acc_valid_i && $stable(r_acc_i))
    else $error("accumulator changed or dropped before its transfer");

  // a stalled result on d is held steady
  d_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    d_valid_i && !d_ready_i |=> d_valid_i && $stable(d_data_i))
    else $error("d output changed while stalled");

endmodule

//--- design/mac_top.sv
`timescale 1ns/100ps

module mac_top #(
  parameter int unsigned max_len = 16
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       reg_we_i,
  input  logic [1:0]                 reg_addr_i,
  input  logic [mac_pkg::data_w-1:0] reg_wdata_i,
  output logic [mac_pkg::data_w-1:0] reg_rdata_o,
  input  logic                       a_valid_i,
  output logic                       a_ready_o,
  input  logic [mac_pkg::data_w-1:0] a_data_i,
  input  logic                       b_valid_i,
  output logic                       b_ready_o,
  input  logic [mac_pkg::data_w-1:0] b_data_i,
  input  logic                       c_valid_i,
  output logic                       c_ready_o,
  input  logic [mac_pkg::data_w-1:0] c_data_i,
  output logic                       d_valid_o,
  input  logic                       d_ready_i,
  output logic [mac_pkg::data_w-1:0] d_data_o,
  output logic                       done_o
);

  import mac_pkg::*;

  localparam int unsigned cnt_w = $clog2(max_len) + 1;

  logic               start;
  logic               clear;
  logic [cnt_w-1:0]   len;
  logic [shift_w-1:0] shift;
  logic               simple_mul;
  logic               enable;
  logic               busy;
  logic               done;
  logic               out_fire;
  logic [cnt_w-1:0]   cnt;

  // host registers steering the engine and the sequencer
  mac_regfile #(
    .max_len (max_len)
  ) mac_regfile_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .reg_we_i     (reg_we_i),
    .reg_addr_i   (reg_addr_i),
    .reg_wdata_i  (reg_wdata_i),
    .reg_rdata_o  (reg_rdata_o),
    .busy_i       (busy),
    .done_i       (done),
    .cnt_i        (cnt),
    .start_o      (start),
    .clear_o      (clear),
    .len_o        (len),
    .shift_o      (shift),
    .simple_mul_o (simple_mul),
    .enable_o     (enable)
  );

  mac_ctrl #(
    .max_len (max_len)
  ) mac_ctrl_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start),
    .clear_i      (clear),
    .simple_mul_i (simple_mul),
    .len_i        (len),
    .out_fire_i   (out_fire),
    .busy_o       (busy),
    .done_o       (done)
  );

  mac_engine #(
    .max_len (max_len)
  ) mac_engine_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (clear),
    .enable_i     (enable),
    .start_i      (start),
    .simple_mul_i (simple_mul),
    .len_i        (len),
    .shift_i      (shift),
    .a_valid_i    (a_valid_i),
    .a_ready_o    (a_ready_o),
    .a_data_i     (a_data_i),
    .b_valid_i    (b_valid_i),
    .b_ready_o    (b_ready_o),
    .b_data_i     (b_data_i),
    .c_valid_i    (c_valid_i),
    .c_ready_o    (c_ready_o),
    .c_data_i     (c_data_i),
    .d_valid_o    (d_valid_o),
    .d_ready_i    (d_ready_i),
    .d_data_o     (d_data_o),
    .out_fire_o   (out_fire),
    .cnt_o        (cnt)
  );

  assign done_o = done;

endmodule

//--- design/mac_engine.sv
`timescale 1ns/100ps

module mac_engine #(
  parameter int unsigned max_len = 16
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        clear_i,
  input  logic                        enable_i,
  input  logic                        start_i,
  input  logic                        simple_mul_i,
  input  logic [$clog2(max_len):0]    len_i,
  input  logic [mac_pkg::shift_w-1:0] shift_i,
  input  logic                        a_valid_i,
  output logic                        a_ready_o,
  input  logic [mac_pkg::data_w-1:0]  a_data_i,
  input  logic                        b_valid_i,
  output logic                        b_ready_o,
  input  logic [mac_pkg::data_w-1:0]  b_data_i,
  input  logic                        c_valid_i,
  output logic                        c_ready_o,
  input  logic [mac_pkg::data_w-1:0]  c_data_i,
  output logic                        d_valid_o,
  input  logic                        d_ready_i,
  output logic [mac_pkg::data_w-1:0]  d_data_o,
  output logic                        out_fire_o,
  output logic [$clog2(max_len):0]    cnt_o
);

  import mac_pkg::*;

  localparam int unsigned cnt_w = $clog2(max_len) + 1;
  // the sum of max_len products needs log2(max_len) guard bits
  localparam int unsigned acc_w = prod_w + $clog2(max_len);

  logic signed [prod_w-1:0] mult;
  logic signed [prod_w-1:0] r_mult;
  logic                     r_mult_valid;
  logic signed [acc_w-1:0]  r_mult_ext;
  logic signed [acc_w-1:0]  c_shifted;
  logic signed [acc_w-1:0]  r_acc;
  logic                     r_acc_valid;
  logic signed [acc_w-1:0]  d_full;
  logic signed [acc_w-1:0]  d_shifted;
  logic [cnt_w-1:0]         r_cnt;
  logic                     acc_ready;
  logic                     mult_out_ready;
  logic                     ab_fire;
  logic                     mult_fire;
  logic                     c_fire;
  logic                     acc_fire;

  // c is sign-extended to the accumulator width, then aligned to the product format
  assign c_shifted  = acc_w'($signed(c_data_i)) <<< shift_i;
  assign mult       = $signed(a_data_i) * $signed(b_data_i);
  assign r_mult_ext = acc_w'(r_mult);

  // ready travels backwards combinationally and may look at valid, never the reverse
  // the accumulator can take a product while it holds no finished result or that result leaves
  assign acc_ready      = ~r_acc_valid | d_ready_i;
  assign mult_out_ready = simple_mul_i ? d_ready_i : acc_ready;

  // every fire is qualified by enable so that a disabled engine freezes completely
  assign ab_fire   = enable_i & a_valid_i & b_valid_i & (~r_mult_valid | mult_out_ready);
  assign mult_fire = enable_i & r_mult_valid & mult_out_ready;
  assign c_fire    = enable_i & ~simple_mul_i & c_valid_i & acc_ready;
  assign acc_fire  = enable_i & r_acc_valid & d_ready_i;

  // a and b are consumed as a pair, so both see the same ready
  assign a_ready_o = ab_fire;
  assign b_ready_o = ab_fire;
  assign c_ready_o = c_fire;

  // product pipeline register, loaded on every a/b pair transfer
  always_ff @(posedge clk_i) begin
    if (ab_fire) begin
      r_mult <= mult;
    end
  end

  // the product stays valid until it is passed on, then refills or empties
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_mult_valid <= 1'b0;
    end else if (clear_i) begin
      r_mult_valid <= 1'b0;
    end else if (ab_fire) begin
      r_mult_valid <= 1'b1;
    end else if (mult_fire) begin
      r_mult_valid <= 1'b0;
    end
  end

  // accumulator preloaded from c, a product arriving alongside c joins the preload
  always_ff @(posedge clk_i) begin
    if (c_fire && mult_fire) begin
      r_acc <= c_shifted + r_mult_ext;
    end else if (c_fire) begin
      r_acc <= c_shifted;
    end else if (mult_fire && !simple_mul_i) begin
      r_acc <= r_acc + r_mult_ext;
    end
  end

  // the sum is complete when the product that finds the counter at len is absorbed
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_acc_valid <= 1'b0;
    end else if (clear_i) begin
      r_acc_valid <= 1'b0;
    end else if (mult_fire && !simple_mul_i && (r_cnt == len_i)) begin
      r_acc_valid <= 1'b1;
    end else if (acc_fire) begin
      r_acc_valid <= 1'b0;
    end
  end

  // product counter, armed at 1 by start and stopping at len
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_cnt <= '0;
    end else if (clear_i) begin
      r_cnt <= '0;
    end else if (enable_i) begin
      if (start_i) begin
        r_cnt <= cnt_w'(1);
      end else if (mult_fire && (r_cnt != '0) && (r_cnt < len_i)) begin
        r_cnt <= r_cnt + 1'b1;
      end
    end
  end

  // output source follows the mode, then returns to the stream format
  // there is no rounding or saturation, upper bits are simply dropped
  assign d_full    = simple_mul_i ? r_mult_ext : r_acc;
  assign d_shifted = d_full >>> shift_i;
  assign d_data_o  = d_shifted[data_w-1:0];
  assign d_valid_o = enable_i & (simple_mul_i ? r_mult_valid : r_acc_valid);

  assign out_fire_o = d_valid_o & d_ready_i;
  assign cnt_o      = r_cnt;

endmodule

//--- design/mac_ctrl.sv
`timescale 1ns/100ps

module mac_ctrl #(
  parameter int unsigned max_len = 16
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     start_i,
  input  logic                     clear_i,
  input  logic                     simple_mul_i,
  input  logic [$clog2(max_len):0] len_i,
  input  logic                     out_fire_i,
  output logic                     busy_o,
  output logic                     done_o
);

  import mac_pkg::*;

  localparam int unsigned cnt_w = $clog2(max_len) + 1;

  ctrl_state_e      state_q;
  ctrl_state_e      state_d;
  logic [cnt_w-1:0] fire_cnt_q;
  logic [cnt_w-1:0] fire_cnt_next;

  // number of results sent so far including the one leaving now
  assign fire_cnt_next = fire_cnt_q + 1'b1;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ctrl_idle: begin
        if (start_i) begin
          state_d = ctrl_run;
        end
      end
      ctrl_run: begin
        // a scalar product has one result, multiply mode waits for the len-th
        if (out_fire_i && (!simple_mul_i || (fire_cnt_next == len_i))) begin
          state_d = ctrl_drain;
        end
      end
      ctrl_drain: state_d = ctrl_idle;
      default:    state_d = ctrl_idle;
    endcase
    // a soft clear aborts the job from any state without a done pulse
    if (clear_i) begin
      state_d = ctrl_idle;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ctrl_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // output handshake counter, only consulted in multiply mode
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fire_cnt_q <= '0;
    end else if (clear_i || ((state_q == ctrl_idle) && start_i)) begin
      fire_cnt_q <= '0;
    end else if ((state_q == ctrl_run) && out_fire_i) begin
      fire_cnt_q <= fire_cnt_next;
    end
  end

  assign busy_o = (state_q != ctrl_idle);
  // drain lasts one cycle, which makes done a single pulse per job
  assign done_o = (state_q == ctrl_drain);

endmodule

//--- design/mac_regfile.sv
`timescale 1ns/100ps

module mac_regfile #(
  parameter int unsigned max_len = 16
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   reg_we_i,
  input  logic [1:0]                             reg_addr_i,
  input  logic [mac_pkg::data_w-1:0]             reg_wdata_i,
  output logic [mac_pkg::data_w-1:0]             reg_rdata_o,
  input  logic                                   busy_i,
  input  logic                                   done_i,
  input  logic [$clog2(max_len):0]               cnt_i,
  output logic                                   start_o,
  output logic                                   clear_o,
  output logic [$clog2(max_len):0]               len_o,
  output logic [mac_pkg::shift_w-1:0]            shift_o,
  output logic                                   simple_mul_o,
  output logic                                   enable_o
);

  import mac_pkg::*;

  localparam int unsigned cnt_w = $clog2(max_len) + 1;

  reg_addr_e          addr;
  logic [cnt_w-1:0]   len_q;
  logic [shift_w-1:0] shift_q;
  logic               simple_mul_q;
  logic               enable_q;
  logic               start_q;
  logic               clear_q;
  logic               done_q;

  assign addr = reg_addr_e'(reg_addr_i);

  // configuration registers and the start and clear pulse flops
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      len_q        <= '0;
      shift_q      <= '0;
      simple_mul_q <= 1'b0;
      enable_q     <= 1'b0;
      start_q      <= 1'b0;
      clear_q      <= 1'b0;
    end else begin
      // the pulses last exactly one cycle unless written again
      start_q <= 1'b0;
      clear_q <= 1'b0;
      if (reg_we_i) begin
        case (addr)
          reg_ctrl: begin
            // a start already in flight has not raised busy yet, so it blocks too
            start_q      <= reg_wdata_i[ctrl_start_bit] & ~busy_i & ~start_q;
            clear_q      <= reg_wdata_i[ctrl_clear_bit];
            simple_mul_q <= reg_wdata_i[ctrl_simple_mul_bit];
            enable_q     <= reg_wdata_i[ctrl_enable_bit];
          end
          reg_len:   len_q   <= reg_wdata_i[cnt_w-1:0];
          reg_shift: shift_q <= reg_wdata_i[shift_w-1:0];
          default: begin
            // status is read-only, writes are ignored
          end
        endcase
      end
    end
  end

  // sticky done flag, a new job or a soft clear wipes it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_q <= 1'b0;
    end else if (start_q || clear_q) begin
      done_q <= 1'b0;
    end else if (done_i) begin
      done_q <= 1'b1;
    end
  end

  // combinational read of the addressed word
  // status layout is busy in bit 0, done in bit 1 and the product count from bit 2 up
  always_comb begin
    reg_rdata_o = '0;
    case (addr)
      reg_ctrl: begin
        reg_rdata_o[ctrl_simple_mul_bit] = simple_mul_q;
        reg_rdata_o[ctrl_enable_bit]     = enable_q;
      end
      reg_len:   reg_rdata_o[cnt_w-1:0]   = len_q;
      reg_shift: reg_rdata_o[shift_w-1:0] = shift_q;
      default: begin
        reg_rdata_o[0]         = busy_i;
        reg_rdata_o[1]         = done_q;
        reg_rdata_o[cnt_w+1:2] = cnt_i;
      end
    endcase
  end

  assign start_o      = start_q;
  assign clear_o      = clear_q;
  assign len_o        = len_q;
  assign shift_o      = shift_q;
  assign simple_mul_o = simple_mul_q;
  assign enable_o     = enable_q;

endmodule

//--- design/mac_pkg.sv
package mac_pkg;

  // width of the a, b, c and d stream words and of the register port
  localparam int unsigned data_w = 32;

  // full signed product of two data words
  localparam int unsigned prod_w = 64;

  // fixed-point shift amount, enough to cover a whole product
  localparam int unsigned shift_w = 6;

  // word addresses of the host register block
  typedef enum logic [1:0] {
    reg_ctrl   = 2'd0,
    reg_len    = 2'd1,
    reg_shift  = 2'd2,
    reg_status = 2'd3
  } reg_addr_e;

  // bit positions inside reg_ctrl
  // start and clear are pulses, simple_mul and enable are stored levels
  localparam int unsigned ctrl_start_bit      = 0;
  localparam int unsigned ctrl_clear_bit      = 1;
  localparam int unsigned ctrl_simple_mul_bit = 2;
  localparam int unsigned ctrl_enable_bit     = 3;

  // job sequencer states
  typedef enum logic [1:0] {
    ctrl_idle  = 2'd0,
    ctrl_run   = 2'd1,
    ctrl_drain = 2'd2
  } ctrl_state_e;

endpackage
